// ==== src/predecodePkg.sv ====
// predecode package: bundle geometry, record, class and status types, bus map
package predecodePkg;

  localparam int ParcelBits = 16;
  localparam int NumParcels = 15;
  localparam int OffBits    = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fetch bundle, parcel 0 in the low bits
  typedef struct packed {
    logic                                  spare;    // bit 255
    logic [NumParcels-1:0]                 endMark;  // set = last parcel of an instr
    logic [NumParcels-1:0][ParcelBits-1:0] parcel;
  } bundleT;

  // bit 0: longer than one parcel, bit 1: longer than two
  typedef logic [1:0] magicT;

  // first 32 bits of an instruction, read one of two ways
  typedef union packed {
    struct packed {
      logic [23:0] operand;
      logic [7:0]  mainOp;
    } mainForm;                // long form, magic[0] set
    struct packed {
      logic [25:0] operand;
      logic [5:0]  subOp;
    } subForm;                 // short form, magic[0] clear
  } instrWordT;

  typedef struct packed {
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic jump;
    logic sys;
  } classT;

  typedef struct packed {
    instrWordT          instr;
    logic [OffBits-1:0] off;   // parcel index of the first parcel
    logic [1:0]         len;   // 1 to 3 parcels
    classT              cls;
  } predRecT;

  typedef struct packed {
    logic [24:0] pad;
    logic [3:0]  count;        // records waiting in the FIFO
    logic        hasJump;
    logic        error;
    logic        busy;
  } statusT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // word addresses on the bus
  localparam logic [3:0] AddrBundleLo = 4'd0;  // words 0 to 7
  localparam logic [3:0] AddrStart    = 4'd8;
  localparam logic [3:0] AddrStatus   = 4'd9;
  localparam logic [3:0] AddrHeader   = 4'd10;
  localparam logic [3:0] AddrPop      = 4'd11;

endpackage

// ==== src/instrClassifier.sv ====
// instruction classifier: maps one instruction word and its length code to class flags
module instrClassifier (
  input  predecodePkg::instrWordT word,
  input  predecodePkg::magicT     magic,
  output predecodePkg::classT     cls
);

  logic [5:0] subOp;
  logic [7:0] mainOp;
  logic       shortForm;
  logic       longAluMul;
  logic       longMem;

  assign subOp     = word.subForm.subOp;
  assign mainOp    = word.mainForm.mainOp;
  assign shortForm = ~magic[0];

  // long form groups shared by two classes each
  assign longAluMul = mainOp <= 8'd31;
  assign longMem    = (mainOp >= 8'd64) && (mainOp <= 8'd95);

  always_comb begin
    cls = '0;
    if (shortForm) begin
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // short form, 6-bit sub opcode
      cls.alu   = subOp <= 6'd15;
      cls.shift = (subOp >= 6'd17) && (subOp <= 6'd31) && subOp[0];  // odd codes only
      cls.jump  = (subOp >= 6'd48) && (subOp <= 6'd51);
    end else begin
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // long form, 8-bit main opcode
      cls.alu   = longAluMul && !mainOp[2];
      cls.mul   = longAluMul && mainOp[2];
      cls.load  = longMem && !mainOp[0];
      cls.store = longMem && mainOp[0];
      cls.jump  = ((mainOp >= 8'd160) && (mainOp <= 8'd175)) ||  // cond jumps
                  (mainOp == 8'd181);                           // uncond jump
      cls.sys   = mainOp == 8'd255;
    end
  end

endmodule

// ==== src/bundleScanner.sv ====
// bundle scanner: walks the parcels from the start offset and emits one record per instruction
module bundleScanner #(
  parameter int MaxInstr = 12
) (
  input  logic                             clk,
  input  logic                             rst,
  input  predecodePkg::bundleT             bundle,
  input  logic                             startValid,
  input  logic [predecodePkg::OffBits-1:0] startOff,
  input  logic                             full,
  output logic                             push,
  output predecodePkg::predRecT            rec,
  output logic                             busy,
  output logic                             error,
  output logic                             hasJump
);

  localparam int CntBits = $clog2(MaxInstr + 1);
  localparam logic [CntBits-1:0] MaxCount = CntBits'(MaxInstr);
  localparam logic [predecodePkg::OffBits-1:0] EndOff =
    predecodePkg::OffBits'(predecodePkg::NumParcels);
  localparam int ExtBits = (predecodePkg::NumParcels + 1) * predecodePkg::ParcelBits;

  logic [predecodePkg::OffBits-1:0] cursor;
  logic [predecodePkg::OffBits-1:0] nextCursor;
  logic [CntBits-1:0]               instrCnt;
  logic [predecodePkg::NumParcels+2:0] endExt;
  logic [ExtBits-1:0]               parcelExt;
  logic e0, e1, e2;
  logic complete, atEnd, overLimit;
  predecodePkg::magicT     magic;
  predecodePkg::instrWordT word;
  predecodePkg::classT     cls;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // look at up to three parcels from the cursor
  assign endExt    = {3'b000, bundle.endMark};            // no end marks past parcel 14
  assign parcelExt = {{predecodePkg::ParcelBits{1'b0}}, bundle.parcel};
  assign e0 = endExt[{1'b0, cursor}];
  assign e1 = endExt[{1'b0, cursor} + 5'd1];
  assign e2 = endExt[{1'b0, cursor} + 5'd2];

  assign magic    = {~e0 & ~e1, ~e0};
  assign complete = e0 | e1 | e2;
  assign word     = parcelExt[cursor * predecodePkg::ParcelBits +: 32];

  instrClassifier classifier (
    .word  (word),
    .magic (magic),
    .cls   (cls)
  );

  assign rec.instr = word;
  assign rec.off   = cursor;
  assign rec.len   = 2'd1 + {1'b0, magic[0]} + {1'b0, magic[1]};
  assign rec.cls   = cls;

  assign atEnd      = cursor == EndOff;
  assign overLimit  = instrCnt == MaxCount;   // one more would be past the limit
  assign nextCursor = cursor + predecodePkg::OffBits'(rec.len);

  assign push = busy & ~atEnd & complete & ~overLimit & ~full;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      error    <= 1'b0;
      hasJump  <= 1'b0;
      cursor   <= '0;
      instrCnt <= '0;
    end else if (!busy) begin
      if (startValid) begin
        busy     <= 1'b1;
        error    <= startOff == EndOff;
        hasJump  <= 1'b0;
        cursor   <= startOff;
        instrCnt <= '0;
      end
    end else if (atEnd) begin
      busy <= 1'b0;                      // started past the last parcel
    end else if (!complete || overLimit) begin
      busy  <= 1'b0;
      error <= 1'b1;
    end else if (!full) begin
      cursor   <= nextCursor;
      instrCnt <= instrCnt + 1'b1;
      hasJump  <= hasJump | cls.jump;
      if (nextCursor == EndOff) begin
        busy <= 1'b0;                    // last record goes out this cycle
      end
    end
  end

  // while the FIFO is full the cursor waits, so no record is skipped
  holdWhileFull: assert property (@(posedge clk) disable iff (rst)
    (busy && full) |=> $stable(cursor))
    else $error("scanner moved past a record while the FIFO was full");

endmodule

// ==== src/recordFifo.sv ====
// record FIFO: circular buffer of decoded records between the scanner and the bus port
module recordFifo #(
  parameter int FifoDepth = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic                  pop,
  input  predecodePkg::predRecT din,
  output predecodePkg::predRecT dout,
  output logic                  full,
  output logic                  empty,
  output logic [3:0]            count
);

  localparam int PtrBits = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam logic [PtrBits-1:0] LastPtr = PtrBits'(FifoDepth - 1);
  localparam logic [3:0] DepthCount = 4'(FifoDepth);

  predecodePkg::predRecT mem [FifoDepth];
  logic [PtrBits-1:0] rdPtr;
  logic [PtrBits-1:0] wrPtr;
  logic doPush, doPop;

  assign full   = count == DepthCount;
  assign empty  = count == 4'd0;
  assign doPush = push & ~full;    // dropped when full
  assign doPop  = pop & ~empty;
  assign dout   = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= din;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= 4'd0;
    end else begin
      if (doPush) wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
      if (doPop) rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 4'd1;
        2'b01:   count <= count - 4'd1;
        default: count <= count;      // both or neither
      endcase
    end
  end

  countInRange: assert property (@(posedge clk) disable iff (rst) count <= DepthCount)
    else $error("FIFO count above its depth");

endmodule

// ==== src/wbPredecodePort.sv ====
// Wishbone classic slave: bundle registers, scan start, status, header and record pop
module wbPredecodePort (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             cyc,
  input  logic                             stb,
  input  logic                             we,
  input  logic [3:0]                       adr,
  input  logic [31:0]                      datIn,
  output logic [31:0]                      datOut,
  output logic                             ack,
  output predecodePkg::bundleT             bundle,
  output logic                             startValid,
  output logic [predecodePkg::OffBits-1:0] startOff,
  input  logic                             busy,
  input  logic                             error,
  input  logic                             hasJump,
  input  predecodePkg::predRecT            head,
  input  logic                             empty,
  input  logic [3:0]                       count,
  output logic                             pop
);

  logic [7:0][31:0] bundleWords;
  logic req, isStart, inBundle, accept;
  predecodePkg::statusT status;
  logic [31:0] header;

  assign bundle   = predecodePkg::bundleT'(bundleWords);
  assign req      = cyc & stb & ~ack;                        // one ack per request
  assign inBundle = adr[3] == predecodePkg::AddrBundleLo[3]; // lower eight words
  assign isStart  = we & (adr == predecodePkg::AddrStart);
  assign accept   = req & ~(isStart & busy);                 // start waits for idle scanner

  always_comb begin
    status         = '0;
    status.busy    = busy;
    status.error   = error;
    status.hasJump = hasJump;
    status.count   = count;
    header         = '0;
    header[31]     = ~empty;
    header[13:12]  = head.len;
    header[11:8]   = head.off;
    header[6:0]    = head.cls;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      ack        <= 1'b0;
      startValid <= 1'b0;
      pop        <= 1'b0;
    end else begin
      ack        <= accept;
      startValid <= accept & isStart;
      pop        <= accept & ~we & (adr == predecodePkg::AddrPop) & ~empty;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && we) begin
      if (inBundle) bundleWords[adr[2:0]] <= datIn;
      else if (isStart) startOff <= datIn[predecodePkg::OffBits-1:0];
    end
    if (accept && !we) begin
      if (inBundle) datOut <= bundleWords[adr[2:0]];
      else begin
        case (adr)
          predecodePkg::AddrStatus: datOut <= status;
          predecodePkg::AddrHeader: datOut <= header;
          predecodePkg::AddrPop:    datOut <= empty ? 32'd0 : head.instr;
          default:                  datOut <= 32'd0;
        endcase
      end
    end
  end

  ackSingle: assert property (@(posedge clk) disable iff (rst)
    ack |-> (cyc && stb) ##1 !ack)
    else $error("ack outside a request or held for two cycles");

endmodule

// ==== src/predecodeTop.sv ====
// predecoder top: connects the bus port, bundle scanner and record FIFO
module predecodeTop #(
  parameter int FifoDepth = 8,
  parameter int MaxInstr  = 12
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [3:0]  adr,
  input  logic [31:0] datIn,
  output logic [31:0] datOut,
  output logic        ack
);

  predecodePkg::bundleT             bundle;
  predecodePkg::predRecT            rec;
  predecodePkg::predRecT            head;
  logic [predecodePkg::OffBits-1:0] startOff;
  logic [3:0]                       count;
  logic startValid, busy, error, hasJump;
  logic push, pop, full, empty;

  wbPredecodePort port (
    .clk, .rst, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack,
    .bundle, .startValid, .startOff, .busy, .error, .hasJump,
    .head, .empty, .count, .pop
  );

  bundleScanner #(.MaxInstr(MaxInstr)) scanner (
    .clk, .rst, .bundle, .startValid, .startOff, .full,
    .push, .rec, .busy, .error, .hasJump
  );

  recordFifo #(.FifoDepth(FifoDepth)) fifo (
    .clk, .rst, .push, .pop, .din(rec), .dout(head), .full, .empty, .count
  );

endmodule

// ==== tests/clockGen.sv ====
// clock and reset generator: free running clock, reset held for a few cycles
module clockGen #(
  parameter int Period      = 8,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1 rst = 1'b0;  // released just after the edge
  end

endmodule

// ==== tests/predecodeModel.svh ====
// predecode reference model: expected records, classes, header and status of a scan
`ifndef PREDECODE_MODEL_SVH
`define PREDECODE_MODEL_SVH

predecodePkg::predRecT expRecs[$];
logic                  expError;
logic                  expJump;

function automatic predecodePkg::classT classOf(input logic [31:0] w, input logic [1:0] mg);
  predecodePkg::classT c;
  int op;
  c = '0;
  if (!mg[0]) begin
    op = int'(w[5:0]);  // short form
    c.alu = op <= 15;
    c.shift = (op >= 17) && (op <= 31) && (op % 2 == 1);
    c.jump = (op >= 48) && (op <= 51);
  end else begin
    op = int'(w[7:0]);
    c.alu = (op <= 31) && ((op & 4) == 0);
    c.mul = (op <= 31) && ((op & 4) != 0);
    c.load = (op >= 64) && (op <= 95) && (op % 2 == 0);
    c.store = (op >= 64) && (op <= 95) && (op % 2 == 1);
    c.jump = ((op >= 160) && (op <= 175)) || (op == 181);
    c.sys = op == 255;
  end
  return c;
endfunction

// walks the bundle like the scanner and fills expRecs, expError, expJump
function automatic void scanModel(input predecodePkg::bundleT b, input int off,
                                  input int maxInstr);
  predecodePkg::predRecT r;
  logic [31:0] w;
  logic [15:0] hi;
  int c;
  int len;
  int k;
  expRecs.delete();
  expError = 1'b0;
  expJump = 1'b0;
  c = off;
  if (off >= predecodePkg::NumParcels) begin
    expError = 1'b1;
    return;
  end
  while (c < predecodePkg::NumParcels) begin
    len = 0;
    for (k = 2; k >= 0; k--) begin
      if ((c + k < predecodePkg::NumParcels) && b.endMark[c + k]) len = k + 1;  // nearest mark
    end
    if (len == 0 || expRecs.size() == maxInstr) begin
      expError = 1'b1;
      break;
    end
    hi = (c + 1 < predecodePkg::NumParcels) ? b.parcel[c + 1] : 16'h0000;
    w = {hi, b.parcel[c]};
    r.instr = w;
    r.off = 4'(c);
    r.len = 2'(len);
    r.cls = classOf(w, {len > 2, len > 1});
    expJump = expJump | r.cls.jump;
    expRecs.push_back(r);
    c = c + len;
  end
endfunction

function automatic logic [31:0] expectedHeader(input predecodePkg::predRecT r);
  logic [31:0] h;
  h = '0;
  h[31] = 1'b1;
  h[13:12] = r.len;
  h[11:8] = r.off;
  h[6:0] = r.cls;
  return h;
endfunction

// status once the scan is over and the FIFO is drained
function automatic logic [31:0] expectedStatus(input logic err, input logic jmp);
  predecodePkg::statusT s;
  s = '0;
  s.error = err;
  s.hasJump = jmp;
  return s;
endfunction

`endif

// ==== tests/predecodeTb.sv ====
// predecoder testbench: bus tasks, scan tests against the reference model, watchdog
module predecodeTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FifoDepth  = 8;
  localparam int MaxInstr   = 12;
  localparam int NumTests   = 6;
  localparam int AckTimeout = 16;

  logic        clk, rst;
  logic        cyc, stb, we, ack;
  logic [3:0]  adr;
  logic [31:0] datIn, datOut;

  int    seed = 32'h637b_d237;
  int    errCount = 0;
  int    testErrs = 0;
  int    passTests = 0;
  int    failTests = 0;
  int    gotRecs = 0;
  string testName = "reset";

  `include "predecodeModel.svh"

  clockGen #(.Period(8), .ResetCycles(2)) clocks (.clk, .rst);

  predecodeTop #(.FifoDepth(FifoDepth), .MaxInstr(MaxInstr)) uut (
    .clk, .rst, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reserved bits of read data must stay zero
  headerSpare: assert property (@(posedge clk) disable iff (rst)
    (ack && !we && adr == predecodePkg::AddrHeader) |-> (datOut[30:14] == 0 && !datOut[7]))
    else begin
      $display("FAIL %s header spare bits expected 0 actual %h", testName, $sampled(datOut));
      errCount++;
    end

  statusSpare: assert property (@(posedge clk) disable iff (rst)
    (ack && !we && adr == predecodePkg::AddrStatus) |-> datOut[31:7] == 0)
    else begin
      $display("FAIL %s status spare bits expected 0 actual %h", testName, $sampled(datOut));
      errCount++;
    end

  task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL %s %s expected %h actual %h", testName, what, exp, act);
      errCount++;
    end
  endtask

  // one Wishbone classic cycle, held until the edge that sees ack
  task automatic transfer(input logic wr, input logic [3:0] a, input logic [31:0] d,
                          output logic [31:0] q, output int waited);
    waited = 0;
    q = '0;
    cyc = 1'b1;
    stb = 1'b1;
    we = wr;
    adr = a;
    datIn = d;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!ack && waited < AckTimeout);
    if (ack) begin
      q = datOut;
      @(posedge clk);
      #1;
    end else begin
      $display("%s: no ack from the DUT at address %0d within %0d cycles",
               testName, a, AckTimeout);
      errCount++;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic writeWord(input logic [3:0] a, input logic [31:0] d, output int waited);
    logic [31:0] q;
    transfer(1'b1, a, d, q, waited);
  endtask

  task automatic readWord(input logic [3:0] a, output logic [31:0] q);
    int waited;
    transfer(1'b0, a, 32'd0, q, waited);
  endtask

  task automatic loadBundle(input predecodePkg::bundleT b);
    logic [255:0] flat;
    int waited;
    flat = b;
    for (int k = 0; k < 8; k++) begin
      writeWord(predecodePkg::AddrBundleLo + 4'(k), flat[32 * k +: 32], waited);
    end
  endtask

  function automatic predecodePkg::bundleT randomBundle(input logic [14:0] marks);
    predecodePkg::bundleT b;
    b = '0;
    for (int i = 0; i < predecodePkg::NumParcels; i++) b.parcel[i] = 16'($random(seed));
    b.endMark = marks;
    return b;
  endfunction

  // pops records until the scan is over and the FIFO is empty
  task automatic drainRecords();
    logic [31:0] hd, st, w;
    int polls;
    bit done;
    gotRecs = 0;
    polls = 0;
    done = 0;
    while (!done && polls < 200) begin
      polls++;
      readWord(predecodePkg::AddrHeader, hd);
      if (!hd[31]) begin
        readWord(predecodePkg::AddrStatus, st);
        if (!st[0]) begin
          readWord(predecodePkg::AddrHeader, hd);  // a last push may have landed
          done = !hd[31];
        end
      end
      if (hd[31]) begin
        readWord(predecodePkg::AddrPop, w);
        if (gotRecs < expRecs.size()) begin
          checkValue("header", expectedHeader(expRecs[gotRecs]), hd);
          checkValue("word", expRecs[gotRecs].instr, w);
        end
        gotRecs++;
      end
    end
    if (!done) begin
      $display("%s: scan did not finish or the FIFO never emptied", testName);
      errCount++;
    end
    checkValue("record count", expRecs.size(), gotRecs);
    readWord(predecodePkg::AddrStatus, st);
    checkValue("status", expectedStatus(expError, expJump), st);
  endtask

  task automatic runScan(input predecodePkg::bundleT b, input int off);
    int waited;
    loadBundle(b);
    scanModel(b, off, MaxInstr);
    writeWord(predecodePkg::AddrStart, off, waited);
    drainRecords();
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testErrs = errCount;
  endtask

  task automatic finishTest();
    if (errCount == testErrs) begin
      passTests++;
      $display("test %s: ok", testName);
    end else begin
      failTests++;
      $display("test %s: %0d errors", testName, errCount - testErrs);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    repeat (NumTests * 400) @(posedge clk);
    $display("watchdog: run did not finish in %0d cycles", NumTests * 400);
    $display("Checks failed");
    $finish;
  end

  initial begin
    predecodePkg::bundleT  b;
    predecodePkg::predRecT first[$];
    logic [31:0] q;
    int waited;
    int n1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datIn = '0;
    wait (!rst);
    @(posedge clk);
    #1;

    beginTest("reset");
    readWord(predecodePkg::AddrStatus, q);
    checkValue("status", 32'd0, q);
    readWord(predecodePkg::AddrHeader, q);
    checkValue("header valid", 32'd0, {31'd0, q[31]});
    readWord(predecodePkg::AddrPop, q);
    checkValue("pop on empty", 32'd0, q);
    finishTest();

    beginTest("all_marks");
    runScan(randomBundle(15'h7fff), 0);
    checkValue("records", 32'd12, gotRecs);
    finishTest();

    beginTest("random");
    for (int i = 0; i < 10; i++) begin
      runScan(randomBundle(15'($random(seed)) | 15'($random(seed))),
              $unsigned($random(seed)) % 15);
    end
    finishTest();

    beginTest("offset15");
    runScan(randomBundle(15'h7fff), 15);
    finishTest();

    beginTest("no_end_mark");
    runScan(randomBundle(15'b111_1111_1000_0011), 0);  // parcels 2 to 6 unmarked
    finishTest();

    // second start lands while the first scan is still pushing
    beginTest("backpressure");
    b = randomBundle(15'h7fff);
    loadBundle(b);
    scanModel(b, 10, MaxInstr);
    first = expRecs;
    n1 = first.size();
    writeWord(predecodePkg::AddrStart, 32'd10, waited);
    writeWord(predecodePkg::AddrStart, 32'd9, waited);
    assert (waited > n1) else begin
      $display("%s: second start acked after %0d cycles, before the first scan ended",
               testName, waited);
      errCount++;
    end
    scanModel(b, 9, MaxInstr);
    foreach (expRecs[i]) begin
      first.push_back(expRecs[i]);
    end
    expRecs = first;
    drainRecords();
    finishTest();

    $display("%0d tests passed, %0d tests failed", passTests, failTests);
    if (errCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tests
src/predecodePkg.sv
src/instrClassifier.sv
src/bundleScanner.sv
src/recordFifo.sv
src/wbPredecodePort.sv
src/predecodeTop.sv
tests/clockGen.sv
tests/predecodeTb.sv

// ==== Bender.yml ====
package:
  name: predecode

sources:
  - src/predecodePkg.sv
  - src/instrClassifier.sv
  - src/bundleScanner.sv
  - src/recordFifo.sv
  - src/wbPredecodePort.sv
  - src/predecodeTop.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/clockGen.sv
      - tests/predecodeTb.sv
